// File: compile.f
+incdir+design
design/smc_mac_pkg.sv
design/smc_access_counter.sv
design/smc_read_assembler.sv
design/smc_write_lane_select.sv
design/smc_mac.sv
verif/tb_clk_gen.sv
verif/tb_smc_mac.sv

// File: design/smc_access_counter.sv
// transfer-size register, access-count decode, access down-counter, last-access flag
`default_nettype none

`include "smc_mac_macros.svh"

module smc_access_counter (
  input  wire logic                    sys_clk18,
  input  wire logic                    n_sys_reset18,
  input  wire logic                    valid_access,  // address cycle of new transfer
  input  wire smc_mac_pkg::xfer_size_e xfer_size,     // valid with valid_access
  input  wire logic                    smc_done,      // end of one external access
  input  wire smc_mac_pkg::smc_state_e smc_nextstate,
  output smc_mac_pkg::mac_access_t     mac_access,
  output logic                         mac_done,      // last access of the transfer
  output smc_mac_pkg::xfer_size_e      v_xfer_size
);

  import smc_mac_pkg::*;

  xfer_size_e  r_xfer_size;   // size held for the whole transfer
  access_cnt_t r_num_access;  // accesses left after the current one
  access_cnt_t num_accesses;  // decoded load value
  logic        access_done;   // an access that really moved data

  // --------------------
  // access count decode
  // --------------------

  always_comb
  begin
    case (xfer_size)
      xsiz_16: num_accesses = `SMC_NACC_16;
      xsiz_32: num_accesses = `SMC_NACC_32;
      default: num_accesses = `SMC_NACC_8; // byte and unused code
    endcase
  end

  // accesses ending in store or idle don't count
  assign access_done = smc_done
                       && (smc_nextstate != smc_store)
                       && (smc_nextstate != smc_idle);

  // --------------------
  // size and count registers
  // --------------------

  always_ff @(posedge sys_clk18 or negedge n_sys_reset18)
  begin
    if (!n_sys_reset18)
    begin
      r_xfer_size  <= xsiz_8;
      r_num_access <= '0;
    end
    else if (valid_access) // new transfer wins over a decrement
    begin
      r_xfer_size  <= xfer_size;
      r_num_access <= num_accesses;
    end
    else if (access_done)
    begin
      r_num_access <= r_num_access - access_cnt_t'(1);
    end
  end

  // last access when nothing remains
  assign mac_done = (r_num_access == '0);

  // live size in the address cycle, held size after it
  assign v_xfer_size = valid_access ? xfer_size : r_xfer_size;

  // state for the read and write paths
  assign mac_access.xfer_size  = r_xfer_size;
  assign mac_access.num_access = r_num_access;

endmodule : smc_access_counter

`default_nettype wire

// File: design/smc_mac.sv
// top of the multiple-access block, counter and read and write data paths
`default_nettype none

module smc_mac (
  input  wire logic                    sys_clk18,
  input  wire logic                    n_sys_reset18,
  input  wire logic                    valid_access,
  input  wire smc_mac_pkg::xfer_size_e xfer_size,
  input  wire logic                    smc_done,
  input  wire smc_mac_pkg::smc_state_e smc_nextstate,
  input  wire logic                    latch_data,
  input  wire smc_mac_pkg::byte_t      data_smc,
  input  wire smc_mac_pkg::word_t      write_data,
  output smc_mac_pkg::access_cnt_t     r_num_access,  // access counter
  output logic                         mac_done,
  output smc_mac_pkg::xfer_size_e      v_xfer_size,
  output smc_mac_pkg::word_t           read_data,     // to internal bus
  output smc_mac_pkg::word_t           smc_data       // to external bus
);

  import smc_mac_pkg::*;

  mac_access_t mac_access; // held size and count

  // --------------------
  // access counter
  // --------------------

  smc_access_counter u_access_counter (
    .sys_clk18     (sys_clk18),
    .n_sys_reset18 (n_sys_reset18),
    .valid_access  (valid_access),
    .xfer_size     (xfer_size),
    .smc_done      (smc_done),
    .smc_nextstate (smc_nextstate),
    .mac_access    (mac_access),
    .mac_done      (mac_done),
    .v_xfer_size   (v_xfer_size)
  );

  // --------------------
  // data paths
  // --------------------

  smc_read_assembler u_read_assembler (
    .sys_clk18     (sys_clk18),
    .n_sys_reset18 (n_sys_reset18),
    .latch_data    (latch_data),
    .data_smc      (data_smc),
    .mac_access    (mac_access),
    .read_data     (read_data)
  );

  smc_write_lane_select u_write_lane_select (
    .write_data (write_data),
    .mac_access (mac_access),
    .smc_data   (smc_data)
  );

  assign r_num_access = mac_access.num_access; // count for the controller

endmodule : smc_mac

`default_nettype wire

// File: design/smc_mac_macros.svh
// widths and access-count constants for the smc multiple-access block
`ifndef SMC_MAC_MACROS_SVH
`define SMC_MAC_MACROS_SVH

// --------------------
// bus widths
// --------------------

// internal bus data width
`define SMC_DATA_W 32

// external memory bus, 8-bit only
`define SMC_BYTE_W 8

// --------------------
// counter and state widths
// --------------------

`define SMC_CNT_W 2   // holds 0..3 remaining accesses
`define SMC_STATE_W 5 // one-hot controller state

// --------------------
// accesses still to do after the first one
// --------------------

`define SMC_NACC_8 2'd0  // byte, one access
`define SMC_NACC_16 2'd1 // halfword, two accesses
`define SMC_NACC_32 2'd3 // word, four accesses

`endif

// File: design/smc_mac_pkg.sv
// data typedefs, size and state enums, and the access-state struct
`default_nettype none

`include "smc_mac_macros.svh"

package smc_mac_pkg;

  // --------------------
  // data vectors
  // --------------------

  typedef logic [`SMC_DATA_W-1:0] word_t;     // internal bus word
  typedef logic [`SMC_BYTE_W-1:0] byte_t;     // external bus byte
  typedef logic [`SMC_CNT_W-1:0] access_cnt_t; // accesses left after this one

  // transfer size, as seen on the internal bus
  // code 3 is unused and decodes like a byte
  typedef enum logic [1:0] {
    xsiz_8  = 2'd0,
    xsiz_16 = 2'd1,
    xsiz_32 = 2'd2
  } xfer_size_e;

  // next state of the external controller, one-hot
  typedef enum logic [`SMC_STATE_W-1:0] {
    smc_idle  = 5'b00001,
    smc_le    = 5'b00010, // address latch enable
    smc_rw    = 5'b00100, // read/write strobe phase
    smc_store = 5'b01000, // wait for data store
    smc_float = 5'b10000  // bus turnaround
  } smc_state_e;

  // registered size and count, shared by both data paths
  typedef struct packed {
    xfer_size_e  xfer_size;
    access_cnt_t num_access;
  } mac_access_t;

endpackage : smc_mac_pkg

`default_nettype wire

// File: design/smc_read_assembler.sv
// read byte collection register and read-data replication mux
`default_nettype none

module smc_read_assembler (
  input  wire logic                     sys_clk18,
  input  wire logic                     n_sys_reset18,
  input  wire logic                     latch_data,  // data_smc holds a valid byte
  input  wire smc_mac_pkg::byte_t       data_smc,    // external read byte
  input  wire smc_mac_pkg::mac_access_t mac_access,  // held size and count
  output smc_mac_pkg::word_t            read_data    // to internal bus
);

  import smc_mac_pkg::*;

  word_t r_read_data; // bytes collected so far
  byte_t low_byte;    // byte 0 of the outgoing word

  // --------------------
  // collect read bytes
  // --------------------

  // most significant byte arrives first
  // lanes below the written one are cleared
  always_ff @(posedge sys_clk18 or negedge n_sys_reset18)
  begin
    if (!n_sys_reset18)
    begin
      r_read_data <= '0;
    end
    else if (latch_data)
    begin
      case (mac_access.num_access)
        2'd3:
        begin
          r_read_data <= {data_smc, 24'h0}; // first of four
        end
        2'd2:
        begin
          r_read_data <= {r_read_data[31:24], data_smc, 16'h0};
        end
        2'd1:
        begin
          r_read_data <= {r_read_data[31:16], data_smc, 8'h0};
        end
        default:
        begin
          r_read_data <= {r_read_data[31:8], data_smc}; // upper lanes kept
        end
      endcase
    end
  end

  // --------------------
  // read data mux
  // --------------------

  // live byte bypasses the register on the latching cycle
  assign low_byte = latch_data ? data_smc : r_read_data[7:0];

  always_comb
  begin
    case (mac_access.xfer_size)
      xsiz_32:
      begin
        read_data = {r_read_data[31:8], low_byte};
      end
      xsiz_16:
      begin
        // halfword on both halves of the bus
        read_data = {2{r_read_data[15:8], low_byte}};
      end
      default:
      begin
        read_data = {4{low_byte}}; // byte on all four lanes
      end
    endcase
  end

endmodule : smc_read_assembler

`default_nettype wire

// File: design/smc_write_lane_select.sv
// write byte steering onto the low lane of the external data word
`default_nettype none

module smc_write_lane_select (
  input  wire smc_mac_pkg::word_t       write_data,  // held by internal bus
  input  wire smc_mac_pkg::mac_access_t mac_access,
  output smc_mac_pkg::word_t            smc_data     // to external bus
);

  import smc_mac_pkg::*;

  byte_t wr_byte; // byte for the current access

  // --------------------
  // lane select
  // --------------------

  // msb first, one byte per access
  always_comb
  begin
    case (mac_access.num_access)
      2'd3:    wr_byte = write_data[31:24];
      2'd2:    wr_byte = write_data[23:16];
      2'd1:    wr_byte = write_data[15:8];
      default: wr_byte = write_data[7:0]; // last or only access
    endcase
  end

  // zero-extend, external bus only uses the low lane
  assign smc_data = word_t'(wr_byte);

endmodule : smc_write_lane_select

`default_nettype wire

// File: verif/tb_clk_gen.sv
// clock and power-on reset source for the testbench
`default_nettype none

module tb_clk_gen (
  output logic sys_clk18,
  output logic n_sys_reset18
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int half_period  = 10; // 20 ns clock
  localparam int reset_cycles = 3;

  initial
  begin
    sys_clk18 = 1'b0;
    forever #half_period sys_clk18 = ~sys_clk18;
  end

  initial
  begin
    n_sys_reset18 = 1'b0;                      // held in reset
    repeat (reset_cycles) @(posedge sys_clk18);
    n_sys_reset18 <= 1'b1;                     // release on a rising edge
  end

endmodule : tb_clk_gen

`default_nettype wire

// File: verif/tb_smc_mac.sv
// testbench top for the smc multiple-access block, directed tests with a reference model
`default_nettype none

module tb_smc_mac;

  timeunit 1ns;
  timeprecision 100ps;

  import smc_mac_pkg::*;

  localparam logic [31:0] lfsr_seed = 32'h6b81;
  localparam int          wait_limit = 50; // cycles per wait loop

  logic        sys_clk18;
  logic        n_sys_reset18;
  logic        valid_access;
  xfer_size_e  xfer_size;
  logic        smc_done;
  smc_state_e  smc_nextstate;
  logic        latch_data;
  byte_t       data_smc;
  word_t       write_data;
  access_cnt_t r_num_access;
  logic        mac_done;
  xfer_size_e  v_xfer_size;
  word_t       read_data;
  word_t       smc_data;

  // reference model state
  access_cnt_t exp_cnt;
  xfer_size_e  exp_size;
  word_t       exp_reg;

  logic [31:0] lfsr_state = lfsr_seed;
  int          errors     = 0;
  int          checks     = 0;
  int          timeouts   = 0;

  tb_clk_gen u_clk_gen (
    .sys_clk18     (sys_clk18),
    .n_sys_reset18 (n_sys_reset18)
  );

  smc_mac u_smc_mac (
    .sys_clk18     (sys_clk18),
    .n_sys_reset18 (n_sys_reset18),
    .valid_access  (valid_access),
    .xfer_size     (xfer_size),
    .smc_done      (smc_done),
    .smc_nextstate (smc_nextstate),
    .latch_data    (latch_data),
    .data_smc      (data_smc),
    .write_data    (write_data),
    .r_num_access  (r_num_access),
    .mac_done      (mac_done),
    .v_xfer_size   (v_xfer_size),
    .read_data     (read_data),
    .smc_data      (smc_data)
  );

  // --------------------
  // helpers
  // --------------------

  // fibonacci lfsr, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] rand_bits(input int nbits);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < nbits; i++)
    begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      val        = {val[30:0], fb};
    end
    return val;
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp)
    else
    begin
      errors++;
      $display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  // accesses left after the first: 0, 1 or 3
  function automatic access_cnt_t count_for_size(input xfer_size_e size);
    case (size)
      xsiz_16: return 2'd1;
      xsiz_32: return 2'd3;
      default: return 2'd0; // byte, unused code too
    endcase
  endfunction

  // replicated read word from the model register
  function automatic word_t exp_read(input logic latch, input byte_t live);
    byte_t lo;
    lo = latch ? live : exp_reg[7:0]; // live byte on the latching cycle
    case (exp_size)
      xsiz_32: return {exp_reg[31:8], lo};
      xsiz_16: return {exp_reg[15:8], lo, exp_reg[15:8], lo};
      default: return {lo, lo, lo, lo};
    endcase
  endfunction

  // write byte picked by the count, msb first, zero-extended
  function automatic word_t exp_smc_data(input word_t wd, input access_cnt_t cnt);
    return {24'h0, wd[8*cnt +: 8]};
  endfunction

  // lane written by count, lower lanes cleared
  task automatic model_latch(input byte_t b);
    case (exp_cnt)
      2'd3:    exp_reg = {b, 24'h0};
      2'd2:    exp_reg = {exp_reg[31:24], b, 16'h0};
      2'd1:    exp_reg = {exp_reg[31:16], b, 8'h0};
      default: exp_reg = {exp_reg[31:8], b}; // upper lanes kept
    endcase
  endtask

  // address cycle, optionally with smc_done in the same cycle
  task automatic start_transfer(input xfer_size_e size, input logic with_done);
    @(posedge sys_clk18);
    valid_access  <= 1'b1;
    xfer_size     <= size;
    smc_done      <= with_done;
    smc_nextstate <= smc_rw;
    @(negedge sys_clk18);
    check_val("v_xfer_size", size, v_xfer_size); // live size
    @(posedge sys_clk18);
    valid_access <= 1'b0;
    smc_done     <= 1'b0;
    exp_size = size;
    exp_cnt  = count_for_size(size); // load wins over decrement
    @(negedge sys_clk18);
    check_val("r_num_access", exp_cnt, r_num_access);
    check_val("mac_done", exp_cnt == 2'd0, mac_done);
  endtask

  // one external access: optional latch, then smc_done
  task automatic do_access(input logic latch, input byte_t b, input smc_state_e next);
    @(posedge sys_clk18);
    latch_data <= latch;
    data_smc   <= b;
    @(negedge sys_clk18);
    check_val("read_data", exp_read(latch, b), read_data);
    check_val("smc_data", exp_smc_data(write_data, exp_cnt), smc_data);
    @(posedge sys_clk18);
    latch_data    <= 1'b0;
    smc_done      <= 1'b1;
    smc_nextstate <= next;
    if (latch)
    begin
      model_latch(b); // register takes the byte on this edge
    end
    @(negedge sys_clk18);
    check_val("r_num_access", exp_cnt, r_num_access); // not yet counted
    check_val("read_data", exp_read(1'b0, 8'h00), read_data);
    @(posedge sys_clk18);
    smc_done      <= 1'b0;
    smc_nextstate <= smc_le;
    if (next != smc_store && next != smc_idle)
    begin
      exp_cnt = exp_cnt - 2'd1;
    end
    @(negedge sys_clk18);
    check_val("r_num_access", exp_cnt, r_num_access);
    check_val("mac_done", exp_cnt == 2'd0, mac_done);
  endtask

  task automatic wait_reset_release();
    int n;
    n = 0;
    while (n_sys_reset18 !== 1'b1 && n < wait_limit)
    begin
      @(posedge sys_clk18);
      n++;
    end
    if (n_sys_reset18 !== 1'b1)
    begin
      timeouts++;
      $display("timeout: reset was never released, at %0t ns", $time);
    end
  endtask

  task automatic wait_mac_done();
    int n;
    n = 0;
    while (mac_done !== 1'b1 && n < wait_limit)
    begin
      @(negedge sys_clk18);
      n++;
    end
    if (mac_done !== 1'b1)
    begin
      timeouts++;
      $display("timeout: mac_done did not rise, at %0t ns", $time);
    end
  endtask

  // --------------------
  // directed tests
  // --------------------

  task automatic test_reset();
    @(negedge sys_clk18);
    check_val("r_num_access", 2'd0, r_num_access);
    check_val("mac_done", 1'b1, mac_done);
    check_val("v_xfer_size", xsiz_8, v_xfer_size);
    check_val("read_data", 32'h0, read_data);
    check_val("smc_data", {24'h0, write_data[7:0]}, smc_data);
  endtask

  task automatic test_word_read();
    byte_t b;
    word_t assembled;
    assembled = '0;
    start_transfer(xsiz_32, 1'b0);
    for (int i = 0; i < 4; i++)
    begin
      b = byte_t'(rand_bits(8));
      if (i == 3)
      begin
        wait_mac_done(); // count at 0 before the last byte
      end
      // last access hands back to idle, no decrement
      do_access(1'b1, b, (i == 3) ? smc_idle : smc_rw);
      assembled = {assembled[23:0], b};
    end
    check_val("read_data", assembled, read_data);
  endtask

  task automatic test_half_byte_reads();
    start_transfer(xsiz_16, 1'b0);
    do_access(1'b1, byte_t'(rand_bits(8)), smc_rw);
    do_access(1'b1, byte_t'(rand_bits(8)), smc_idle);
    start_transfer(xsiz_8, 1'b0);
    do_access(1'b1, byte_t'(rand_bits(8)), smc_idle);
    start_transfer(xfer_size_e'(2'd3), 1'b0); // unused code acts as a byte
    do_access(1'b1, byte_t'(rand_bits(8)), smc_idle);
  endtask

  task automatic test_word_write();
    @(posedge sys_clk18);
    write_data <= rand_bits(32); // held for the transfer
    start_transfer(xsiz_32, 1'b0);
    do_access(1'b0, 8'h00, smc_rw);
    do_access(1'b0, 8'h00, smc_rw);
    do_access(1'b0, 8'h00, smc_rw);
    do_access(1'b0, 8'h00, smc_idle);
  endtask

  task automatic test_decrement_suppress();
    start_transfer(xsiz_32, 1'b0);
    do_access(1'b0, 8'h00, smc_store); // held
    do_access(1'b0, 8'h00, smc_idle);  // held
    do_access(1'b0, 8'h00, smc_le);    // counted
    start_transfer(xsiz_32, 1'b1);     // reload to 3 beats a step to 1
  endtask

  task automatic test_v_xfer_size();
    start_transfer(xsiz_8, 1'b0); // registered was word
    @(posedge sys_clk18);
    xfer_size <= xsiz_32;
    @(negedge sys_clk18);
    check_val("v_xfer_size", exp_size, v_xfer_size);
    @(posedge sys_clk18);
    xfer_size <= xsiz_16;
    @(negedge sys_clk18);
    check_val("v_xfer_size", exp_size, v_xfer_size);
  endtask

  // --------------------
  // main sequence
  // --------------------

  initial
  begin
    valid_access  = 1'b0;
    xfer_size     = xsiz_8;
    smc_done      = 1'b0;
    smc_nextstate = smc_idle;
    latch_data    = 1'b0;
    data_smc      = '0;
    write_data    = rand_bits(32);
    exp_cnt       = '0;
    exp_size      = xsiz_8;
    exp_reg       = '0;

    wait_reset_release();
    test_reset();
    test_word_read();
    test_half_byte_reads();
    test_word_write();
    test_decrement_suppress();
    test_v_xfer_size();

    $display("checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0)
    begin
      $display("sim passed");
    end
    else
    begin
      $display("sim failed");
    end
    $finish;
  end

endmodule : tb_smc_mac

`default_nettype wire
